// File: dv/tb_clk_gen.sv
module tb_clk_gen (
	output logic ftdi_clk_o,
	output logic reset_o
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		ftdi_clk_o = 1'b0;
		forever #2 ftdi_clk_o = ~ftdi_clk_o;	// 4 ns period
	end

	initial begin
		reset_o = 1'b1;
		repeat (8) @(posedge ftdi_clk_o);
		#1 reset_o = 1'b0;	// Released off the edge
	end

endmodule

// File: dv/tb_usb_interface.sv
`include "openadc_consts.svh"

module tb_usb_interface;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_CMDS = 40;
	localparam int CMD_CYCLES = 40;	// Bound per command
	localparam int N_SAMPLES = 12;
	localparam int STALL_CYCLES = 24;	// Bound per streamed byte
	localparam int WD_NS = (N_CMDS * CMD_CYCLES + N_SAMPLES * STALL_CYCLES + 16) * 4;

	logic ftdi_clk, reset, reset_o;
	logic cmdfifo_rxf_i = 1'b0;
	logic cmdfifo_txe_i = 1'b1;
	logic [7:0] cmdfifo_din_i = '0;
	logic cmdfifo_rd_o, cmdfifo_wr_o, cmdfifo_isout_o;
	logic [7:0] cmdfifo_dout_o;
	logic fifo_empty_i = 1'b1;
	logic [7:0] fifo_data_i = '0;
	logic fifo_rd_en_o;
	logic [7:0] status_i;
	logic [31:0] maxsamples_i;
	logic [7:0] gain_o;
	logic hilow_o, trigger_mode_o, cmd_arm_o, trigger_wait_o, adc_clk_src_o;
	logic [31:0] maxsamples_o, trigger_offset_o;
	logic [8:0] phase_o, phase_i;
	logic phase_ld_o, phase_done_i;

	logic [7:0] host_q[$];	// Bytes toward DUT
	logic [7:0] rx_q[$];	// Bytes sent by DUT
	logic [7:0] smp_q[$];	// Sample FIFO contents
	logic [7:0] exp_q[$];
	logic rd_s = 1'b0, wr_s = 1'b0, fre_s = 1'b0;
	logic [7:0] dout_s = '0;
	logic stall_en = 1'b0;
	int ld_cnt = 0, rst_cnt = 0;
	logic [31:0] lcg_state = 32'hcadc_5555;

	tb_clk_gen u_clk (.ftdi_clk_o(ftdi_clk), .reset_o(reset));
	usb_interface uut (.*);

	function logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic fail_run(string msg);
		$display("%0t ns: %s", $time, msg);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_eq(string name, logic [31:0] exp, logic [31:0] act);
		assert (act === exp) else begin
			$display("ERR %0t ns %s expected %0h actual %0h", $time, name, exp, act);
			$display("ERRORS FOUND");
			$fatal(1);
		end
	endtask

	// Outputs stable mid cycle
	always @(negedge ftdi_clk) begin
		rd_s = cmdfifo_rd_o;
		wr_s = cmdfifo_wr_o;
		fre_s = fifo_rd_en_o;
		dout_s = cmdfifo_dout_o;
		if (phase_ld_o) ld_cnt++;
		if (reset_o && !reset) rst_cnt++;	// Soft reset only
	end

	// Host and sample FIFO models act on the edge and drive 1 ns later
	always @(posedge ftdi_clk) begin
		#1;
		if (rd_s && host_q.size() > 0) void'(host_q.pop_front());
		if (wr_s) rx_q.push_back(dout_s);
		if (fre_s && smp_q.size() > 0) void'(smp_q.pop_front());
		cmdfifo_rxf_i = (host_q.size() > 0);
		cmdfifo_din_i = (host_q.size() > 0) ? host_q[0] : 8'h00;
		fifo_empty_i = (smp_q.size() == 0);
		fifo_data_i = (smp_q.size() > 0) ? smp_q[0] : 8'h00;
		cmdfifo_txe_i = stall_en ? (lcg_next() % 3 != 0) : 1'b1;
	end

	task automatic wait_host_drain();
		while (host_q.size() != 0) @(posedge ftdi_clk);
	endtask

	task automatic send_write(logic [5:0] a, logic [7:0] d);
		host_q.push_back({2'b11, a});
		host_q.push_back(d);
		wait_host_drain();
		repeat (2) @(posedge ftdi_clk);	// Write lands within 2 cycles
		#1;
	endtask

	task automatic read_reg(logic [5:0] a, output logic [7:0] got);
		int n;
		n = 0;
		rx_q.delete();
		host_q.push_back({2'b10, a});
		while (rx_q.size() == 0 && n < CMD_CYCLES) begin
			@(posedge ftdi_clk);
			n++;
		end
		#2;
		if (rx_q.size() == 0) fail_run($sformatf("no reply to read of address %0d", a));
		got = rx_q.pop_front();
	endtask

	task automatic read_expect(logic [5:0] a, logic [7:0] exp, string name);
		logic [7:0] got;
		read_reg(a, got);
		check_eq(name, exp, got);
	endtask

	task automatic read_silent(logic [7:0] cmd);
		rx_q.delete();
		host_q.push_back(cmd);
		wait_host_drain();
		repeat (6) @(posedge ftdi_clk);
		#1;
		if (rx_q.size() != 0) fail_run($sformatf("command %0h produced a reply byte", cmd));
		check_eq("cmdfifo_isout_o", 0, cmdfifo_isout_o);
	endtask

	initial begin
		#(WD_NS);
		fail_run("watchdog expired, DUT stopped responding");
	end

	initial begin
		logic [31:0] s, o;
		logic [7:0] g, e, b8;
		int n;
		status_i = 8'h00;
		maxsamples_i = 32'h0000_1F40;
		phase_i = '0;
		phase_done_i = 1'b0;
		@(negedge reset);
		@(posedge ftdi_clk);
		#1;
		// Reset values
		check_eq("gain_o", 0, gain_o);
		check_eq("settings outputs", 0,
			{hilow_o, trigger_mode_o, cmd_arm_o, trigger_wait_o, adc_clk_src_o});
		check_eq("maxsamples_o", maxsamples_i, maxsamples_o);
		check_eq("trigger_offset_o", 0, trigger_offset_o);
		check_eq("phase_o", 0, phase_o);
		check_eq("strobes", 0, {cmdfifo_rd_o, cmdfifo_wr_o, cmdfifo_isout_o,
			fifo_rd_en_o, phase_ld_o, reset_o});
		// Register round trip
		g = lcg_next();
		e = lcg_next();
		s = lcg_next();
		o = lcg_next();
		send_write(`OA_GAIN_ADDR, g);
		send_write(`OA_ECHO_ADDR, e);
		for (int b = 0; b < 4; b++) begin
			send_write(`OA_SAMPLES_ADDR + b, s[8*b +: 8]);
			send_write(`OA_OFFSET_ADDR + b, o[8*b +: 8]);
		end
		read_expect(`OA_GAIN_ADDR, g, "gain readback");
		read_expect(`OA_ECHO_ADDR, e, "echo readback");
		for (int b = 0; b < 4; b++) begin
			read_expect(`OA_SAMPLES_ADDR + b, s[8*b +: 8], "samples readback");
			read_expect(`OA_OFFSET_ADDR + b, o[8*b +: 8], "offset readback");
		end
		check_eq("gain_o", g, gain_o);
		check_eq("maxsamples_o", s, maxsamples_o);
		check_eq("trigger_offset_o", o, trigger_offset_o);
		// Settings decode of bits 1 2 3 5 6
		send_write(`OA_SETTINGS_ADDR, 8'h6E);
		check_eq("settings outputs", 5'b11111,
			{hilow_o, trigger_mode_o, cmd_arm_o, trigger_wait_o, adc_clk_src_o});
		read_expect(`OA_SETTINGS_ADDR, 8'h6E, "settings readback");
		rst_cnt = 0;
		send_write(`OA_SETTINGS_ADDR, 8'h6F);
		repeat (4) @(posedge ftdi_clk);
		#1;
		if (rst_cnt < 1 || rst_cnt > 2)
			fail_run($sformatf("soft reset pulse lasted %0d cycles", rst_cnt));
		read_expect(`OA_SETTINGS_ADDR, 8'h00, "settings after soft reset");
		check_eq("maxsamples_o", maxsamples_i, maxsamples_o);
		// Status and ignored commands
		status_i = lcg_next();
		read_expect(`OA_STATUS_ADDR, status_i, "status readback");
		read_silent({2'b10, 6'd5});	// Unmapped
		read_silent({2'b01, `OA_ECHO_ADDR});	// Bit 7 clear
		// Phase load and capture
		ld_cnt = 0;
		send_write(`OA_PHASE_LSB_ADDR, 8'h5A);
		send_write(`OA_PHASE_MSB_ADDR, 8'h03);
		check_eq("phase_o", 9'h15A, phase_o);
		check_eq("phase_ld_o pulses", 1, ld_cnt);
		phase_i = 9'h1C3;
		phase_done_i = 1'b1;
		@(posedge ftdi_clk);
		#1 phase_done_i = 1'b0;
		read_expect(`OA_PHASE_LSB_ADDR, 8'hC3, "phase lsb readback");
		read_expect(`OA_PHASE_MSB_ADDR, 8'h03, "phase msb readback");
		send_write(`OA_PHASE_MSB_ADDR, 8'h02);
		read_reg(`OA_PHASE_MSB_ADDR, b8);
		check_eq("phase done flag", 0, b8[1]);
		// ADC stream under stalls
		for (int i = 0; i < N_SAMPLES; i++) begin
			b8 = lcg_next();
			smp_q.push_back(b8);
			exp_q.push_back(b8);
		end
		rx_q.delete();
		stall_en = 1'b1;
		host_q.push_back({2'b10, `OA_ADCDATA_ADDR});
		n = 0;
		while ((rx_q.size() < N_SAMPLES + 1 || cmdfifo_isout_o) &&
			n < N_SAMPLES * STALL_CYCLES) begin
			@(posedge ftdi_clk);
			n++;
		end
		#2;
		stall_en = 1'b0;
		if (rx_q.size() != N_SAMPLES + 1)
			fail_run($sformatf("stream delivered %0d bytes", rx_q.size()));
		check_eq("sync byte", `OA_SYNC_BYTE, rx_q.pop_front());
		for (int i = 0; i < N_SAMPLES; i++)
			check_eq("stream byte", exp_q[i], rx_q[i]);
		check_eq("sample FIFO level", 0, smp_q.size());
		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: dv/usb_interface_props.sv
`include "openadc_consts.svh"

module usb_interface_props (
	input logic ftdi_clk,
	input logic reset_o,	// Combined reset covers soft reset too
	input logic cmdfifo_rd_o,
	input logic cmdfifo_wr_o,
	input logic cmdfifo_isout_o,
	input logic cmdfifo_txe_i,
	input logic fifo_rd_en_o,
	input logic fifo_empty_i,
	input logic phase_ld_o,
	input logic [`OA_ST_W-1:0] fsm_state
);
	timeunit 1ns;
	timeprecision 100ps;

	// Bus is half duplex
	a_rd_wr_excl: assert property (@(posedge ftdi_clk) disable iff (reset_o)
		!(cmdfifo_rd_o && cmdfifo_wr_o))
		else $error("host rd and wr strobes high together");

	a_wr_isout: assert property (@(posedge ftdi_clk) disable iff (reset_o)
		cmdfifo_wr_o |-> cmdfifo_isout_o)
		else $error("wr strobe while bus not turned out");

	// Never pop an empty sample FIFO
	a_pop_empty: assert property (@(posedge ftdi_clk) disable iff (reset_o)
		fifo_rd_en_o |-> !fifo_empty_i)
		else $error("sample FIFO popped while empty");

	a_ld_pulse: assert property (@(posedge ftdi_clk) disable iff (reset_o)
		phase_ld_o |=> !phase_ld_o)
		else $error("phase load longer than one cycle");

	// Host full holds the stream with all strobes quiet
	a_stall_quiet: assert property (@(posedge ftdi_clk) disable iff (reset_o)
		(fsm_state == `OA_ST_STREAM_WAIT && !cmdfifo_txe_i) |=>
		(fsm_state == `OA_ST_STREAM_WAIT &&
		!(cmdfifo_rd_o || cmdfifo_wr_o || fifo_rd_en_o)))
		else $error("stream moved on or strobed while host had no room");

endmodule

bind usb_interface usb_interface_props u_props (
	.ftdi_clk(ftdi_clk), .reset_o(reset_o),
	.cmdfifo_rd_o(cmdfifo_rd_o), .cmdfifo_wr_o(cmdfifo_wr_o),
	.cmdfifo_isout_o(cmdfifo_isout_o), .cmdfifo_txe_i(cmdfifo_txe_i),
	.fifo_rd_en_o(fifo_rd_en_o), .fifo_empty_i(fifo_empty_i),
	.phase_ld_o(phase_ld_o), .fsm_state(u_fsm.state)
);

// File: hdl/adc_reg_file.sv
`include "openadc_consts.svh"

module adc_reg_file (
	input logic ftdi_clk,
	input logic reset_i,	// Board reset
	output logic reset_o,	// Board or soft reset
	reg_bus_if.regs bus,
	input logic [`OA_DATA_W-1:0] status_i,
	input logic [`OA_WORD_W-1:0] maxsamples_i,
	output logic [`OA_DATA_W-1:0] gain_o,
	output logic hilow_o,
	output logic trigger_mode_o,
	output logic cmd_arm_o,
	output logic trigger_wait_o,
	output logic adc_clk_src_o,
	output logic [`OA_WORD_W-1:0] maxsamples_o,
	output logic [`OA_WORD_W-1:0] trigger_offset_o,
	output logic phase_wr_o,
	output logic phase_sel_msb_o,
	output logic [`OA_DATA_W-1:0] phase_wdata_o,
	input logic [`OA_DATA_W-1:0] phase_rdata_i
);
	import openadc_pkg::*;

	logic [`OA_DATA_W-1:0] gain_q;
	logic [`OA_DATA_W-1:0] settings_q;
	logic [`OA_DATA_W-1:0] echo_q;
	logic [`OA_WORD_W-1:0] samples_q;
	logic [`OA_WORD_W-1:0] offset_q;
	logic soft_rst_q;
	phase_msb_u phase_stat;

	// Soft reset lags settings bit 0 by one cycle, then clears it
	always_ff @(posedge ftdi_clk or posedge reset_i) begin
		if (reset_i)
			soft_rst_q <= 1'b0;
		else
			soft_rst_q <= settings_q[`OA_SET_RESET];
	end
	assign reset_o = reset_i | soft_rst_q;

	always_ff @(posedge ftdi_clk or posedge reset_o) begin
		if (reset_o) begin
			gain_q <= '0;
			settings_q <= '0;
			echo_q <= '0;
			samples_q <= maxsamples_i;	// Default to full capture depth
			offset_q <= '0;
		end else if (bus.wr_en) begin
			case (bus.addr)
				`OA_GAIN_ADDR: gain_q <= bus.wdata;
				`OA_SETTINGS_ADDR: settings_q <= bus.wdata;
				`OA_ECHO_ADDR: echo_q <= bus.wdata;
				default: ;
			endcase
			for (int b = 0; b < 4; b++) begin	// Byte lanes of wide regs
				if (bus.addr == `OA_SAMPLES_ADDR + b)
					samples_q[8*b +: 8] <= bus.wdata;
				if (bus.addr == `OA_OFFSET_ADDR + b)
					offset_q[8*b +: 8] <= bus.wdata;
			end
		end
	end

	// Read mux, ADC data and holes give no hit
	always_comb begin
		phase_stat = phase_rdata_i;
		bus.rd_data = '0;
		bus.rd_hit = 1'b1;
		case (bus.addr)
			`OA_GAIN_ADDR: bus.rd_data = gain_q;
			`OA_SETTINGS_ADDR: bus.rd_data = settings_q;
			`OA_STATUS_ADDR: bus.rd_data = status_i;	// Straight through
			`OA_ECHO_ADDR: bus.rd_data = echo_q;
			`OA_PHASE_LSB_ADDR: bus.rd_data = phase_rdata_i;
			`OA_PHASE_MSB_ADDR:	// Defined status bits only
				bus.rd_data = {{(`OA_DATA_W-2){1'b0}}, phase_stat.rd.done, phase_stat.rd.ph8};
			default: bus.rd_hit = 1'b0;
		endcase
		for (int b = 0; b < 4; b++) begin
			if (bus.addr == `OA_SAMPLES_ADDR + b) begin
				bus.rd_data = samples_q[8*b +: 8];
				bus.rd_hit = 1'b1;
			end
			if (bus.addr == `OA_OFFSET_ADDR + b) begin
				bus.rd_data = offset_q[8*b +: 8];
				bus.rd_hit = 1'b1;
			end
		end
	end

	assign gain_o = gain_q;
	assign hilow_o = settings_q[`OA_SET_HILOW];
	assign trigger_mode_o = settings_q[`OA_SET_TRIGMODE];	// Trigger polarity
	assign cmd_arm_o = settings_q[`OA_SET_ARM];
	assign trigger_wait_o = settings_q[`OA_SET_TRIGWAIT];
	assign adc_clk_src_o = settings_q[`OA_SET_CLKSRC];	// 1 = ext x4
	assign maxsamples_o = samples_q;
	assign trigger_offset_o = offset_q;

	// Phase regs live in phase_ctrl
	assign phase_sel_msb_o = (bus.addr == `OA_PHASE_MSB_ADDR);
	assign phase_wr_o = bus.wr_en &&
		((bus.addr == `OA_PHASE_LSB_ADDR) || (bus.addr == `OA_PHASE_MSB_ADDR));
	assign phase_wdata_o = bus.wdata;

endmodule

// File: hdl/host_cmd_fsm.sv
`include "openadc_consts.svh"

module host_cmd_fsm (
	input logic ftdi_clk,
	input logic reset,
	input logic cmdfifo_rxf_i,	// Host byte waiting
	input logic cmdfifo_txe_i,	// Host has room
	input logic [`OA_DATA_W-1:0] cmdfifo_din_i,
	output logic cmdfifo_rd_o,
	output logic cmdfifo_wr_o,
	output logic cmdfifo_isout_o,
	output logic [`OA_DATA_W-1:0] cmdfifo_dout_o,
	input logic fifo_empty_i,
	input logic [`OA_DATA_W-1:0] fifo_data_i,	// FWFT head
	output logic fifo_rd_en_o,
	reg_bus_if.seq bus
);

	logic [`OA_ST_W-1:0] state;
	logic [`OA_ADDR_W-1:0] addr_q;
	logic [`OA_DATA_W-1:0] dout_q;
	logic wr_q;
	logic isout_q;

	// Host pops during CMD and WR_DATA only
	assign cmdfifo_rd_o = (state == `OA_ST_CMD) || (state == `OA_ST_WR_DATA);
	assign cmdfifo_wr_o = wr_q;
	assign cmdfifo_dout_o = dout_q;
	assign cmdfifo_isout_o = isout_q;
	assign fifo_rd_en_o = (state == `OA_ST_STREAM_DATA);	// Pop head as it is loaded

	assign bus.addr = addr_q;
	assign bus.wr_en = (state == `OA_ST_WR_DATA);
	assign bus.wdata = cmdfifo_din_i;	// Valid while rd is high

	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			state <= `OA_ST_IDLE;
			wr_q <= 1'b0;
			isout_q <= 1'b0;
		end else begin
			case (state)
				`OA_ST_IDLE: begin
					wr_q <= 1'b0;	// Ends a pending reply byte
					isout_q <= 1'b0;
					if (cmdfifo_rxf_i)
						state <= `OA_ST_CMD;
				end
				`OA_ST_CMD: begin
					if (!cmdfifo_din_i[`OA_CMD_VALID_BIT]) begin
						state <= `OA_ST_IDLE;	// Not a command, drop
					end else if (cmdfifo_din_i[`OA_CMD_WRITE_BIT]) begin
						state <= `OA_ST_WR_WAIT;
					end else begin
						isout_q <= 1'b1;	// Bus turns toward host
						state <= `OA_ST_RD_START;
					end
				end
				`OA_ST_WR_WAIT: begin
					if (cmdfifo_rxf_i)
						state <= `OA_ST_WR_DATA;	// Data byte arrived
				end
				`OA_ST_WR_DATA:
					state <= `OA_ST_IDLE;	// Register takes byte here
				`OA_ST_RD_START: begin
					if (addr_q == `OA_ADCDATA_ADDR) begin
						state <= `OA_ST_STREAM_WAIT;	// Sync byte loaded, not sent yet
					end else if (bus.rd_hit) begin
						wr_q <= 1'b1;	// Txe not checked for single reply
						state <= `OA_ST_IDLE;
					end else begin
						isout_q <= 1'b0;	// Unmapped, no reply
						state <= `OA_ST_IDLE;
					end
				end
				`OA_ST_STREAM_WAIT: begin
					// Hold with no strobe while host is full
					if (cmdfifo_txe_i) begin
						wr_q <= 1'b1;
						if (fifo_empty_i)
							state <= `OA_ST_IDLE;	// Last byte goes out
						else
							state <= `OA_ST_STREAM_DATA;
					end
				end
				`OA_ST_STREAM_DATA: begin
					wr_q <= 1'b0;
					state <= `OA_ST_STREAM_WAIT;
				end
				default: begin
					wr_q <= 1'b0;
					isout_q <= 1'b0;
					state <= `OA_ST_IDLE;
				end
			endcase
		end
	end

	// Address and outgoing byte
	always_ff @(posedge ftdi_clk) begin
		if (state == `OA_ST_CMD)
			addr_q <= cmdfifo_din_i[`OA_ADDR_W-1:0];
		if (state == `OA_ST_RD_START)
			dout_q <= (addr_q == `OA_ADCDATA_ADDR) ? `OA_SYNC_BYTE : bus.rd_data;
		else if (state == `OA_ST_STREAM_DATA)
			dout_q <= fifo_data_i;	// Head being popped
	end

endmodule

// File: hdl/openadc_consts.svh
`ifndef OPENADC_CONSTS_SVH
`define OPENADC_CONSTS_SVH

`define OA_DATA_W	8	// Host byte
`define OA_ADDR_W	6	// Register address field of command
`define OA_WORD_W	32
`define OA_PHASE_W	9

// Register map
`define OA_GAIN_ADDR		6'd0
`define OA_SETTINGS_ADDR	6'd1
`define OA_STATUS_ADDR		6'd2
`define OA_ADCDATA_ADDR		6'd3	// Read only, starts sample stream
`define OA_ECHO_ADDR		6'd4
`define OA_PHASE_LSB_ADDR	6'd9
`define OA_PHASE_MSB_ADDR	6'd10
`define OA_SAMPLES_ADDR		6'd16	// Four bytes, LSB first
`define OA_OFFSET_ADDR		6'd26	// Four bytes, LSB first

`define OA_CMD_VALID_BIT	7
`define OA_CMD_WRITE_BIT	6	// 1 = write, 0 = read
`define OA_SYNC_BYTE		8'hAC

// Settings register bits
`define OA_SET_RESET		0
`define OA_SET_HILOW		1
`define OA_SET_TRIGMODE		2
`define OA_SET_ARM		3
`define OA_SET_TRIGWAIT		5
`define OA_SET_CLKSRC		6

// Sequencer states
`define OA_ST_W			3
`define OA_ST_IDLE		3'd0
`define OA_ST_CMD		3'd1
`define OA_ST_WR_WAIT		3'd2
`define OA_ST_WR_DATA		3'd3
`define OA_ST_RD_START		3'd4
`define OA_ST_STREAM_WAIT	3'd5
`define OA_ST_STREAM_DATA	3'd6

`endif

// File: hdl/openadc_pkg.sv
`include "openadc_consts.svh"

package openadc_pkg;

	// Phase MSB byte as written by host
	typedef struct packed {
		logic [`OA_DATA_W-3:0] rsvd;
		logic load;	// Start phase shift
		logic ph8;	// Phase bit 8
	} phase_msb_wr_t;

	// Same byte as read back
	typedef struct packed {
		logic [`OA_DATA_W-3:0] rsvd;
		logic done;	// Shift finished
		logic ph8;	// Captured phase bit 8
	} phase_msb_rd_t;

	typedef union packed {
		phase_msb_wr_t wr;
		phase_msb_rd_t rd;
	} phase_msb_u;

endpackage

// File: hdl/phase_ctrl.sv
`include "openadc_consts.svh"

module phase_ctrl (
	input logic ftdi_clk,
	input logic reset,
	input logic phase_wr_i,
	input logic phase_sel_msb_i,	// 0 = LSB byte, 1 = MSB byte
	input logic [`OA_DATA_W-1:0] phase_wdata_i,
	output logic [`OA_DATA_W-1:0] phase_rdata_o,
	output logic [`OA_PHASE_W-1:0] phase_o,
	output logic phase_ld_o,
	input logic [`OA_PHASE_W-1:0] phase_i,	// Phase reported by shifter
	input logic phase_done_i
);
	import openadc_pkg::*;

	phase_msb_u wr_view;
	phase_msb_u rd_view;
	logic [`OA_PHASE_W-1:0] phase_in_q;
	logic done_q;

	assign wr_view = phase_wdata_i;

	// Phase word from two byte writes, load from MSB write
	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			phase_o <= '0;
			phase_ld_o <= 1'b0;
		end else begin
			phase_ld_o <= 1'b0;	// Single cycle pulse
			if (phase_wr_i && phase_sel_msb_i) begin
				phase_o[8] <= wr_view.wr.ph8;
				phase_ld_o <= wr_view.wr.load;
			end else if (phase_wr_i) begin
				phase_o[7:0] <= phase_wdata_i;
			end
		end
	end

	// Returned phase, cleared when a new shift is loaded
	always_ff @(posedge ftdi_clk or posedge reset) begin
		if (reset) begin
			phase_in_q <= '0;
			done_q <= 1'b0;
		end else if (phase_ld_o) begin
			phase_in_q <= '0;
			done_q <= 1'b0;
		end else if (phase_done_i) begin
			phase_in_q <= phase_i;
			done_q <= 1'b1;
		end
	end

	always_comb begin
		rd_view = '0;
		rd_view.rd.ph8 = phase_in_q[8];
		rd_view.rd.done = done_q;
	end

	assign phase_rdata_o = phase_sel_msb_i ? rd_view : phase_in_q[7:0];

endmodule

// File: hdl/reg_bus_if.sv
`include "openadc_consts.svh"

interface reg_bus_if;
	logic [`OA_ADDR_W-1:0] addr;	// Latched command address
	logic wr_en;			// One cycle, WR_DATA state
	logic [`OA_DATA_W-1:0] wdata;
	logic [`OA_DATA_W-1:0] rd_data;	// Comb on addr
	logic rd_hit;			// Address is readable

	// Command sequencer side
	modport seq (
		output addr, wr_en, wdata,
		input rd_data, rd_hit
	);

	// Register file side
	modport regs (
		input addr, wr_en, wdata,
		output rd_data, rd_hit
	);

endinterface

// File: hdl/usb_interface.sv
`include "openadc_consts.svh"

module usb_interface (
	input logic ftdi_clk,
	input logic reset,	// Board reset
	output logic reset_o,	// Board or soft reset, to rest of board
	input logic cmdfifo_rxf_i,
	input logic cmdfifo_txe_i,
	input logic [`OA_DATA_W-1:0] cmdfifo_din_i,
	output logic cmdfifo_rd_o,
	output logic cmdfifo_wr_o,
	output logic [`OA_DATA_W-1:0] cmdfifo_dout_o,
	output logic cmdfifo_isout_o,	// Half duplex direction
	input logic fifo_empty_i,
	input logic [`OA_DATA_W-1:0] fifo_data_i,
	output logic fifo_rd_en_o,
	input logic [`OA_DATA_W-1:0] status_i,
	input logic [`OA_WORD_W-1:0] maxsamples_i,
	output logic [`OA_DATA_W-1:0] gain_o,
	output logic hilow_o,
	output logic trigger_mode_o,
	output logic cmd_arm_o,
	output logic trigger_wait_o,
	output logic adc_clk_src_o,
	output logic [`OA_WORD_W-1:0] maxsamples_o,
	output logic [`OA_WORD_W-1:0] trigger_offset_o,
	output logic [`OA_PHASE_W-1:0] phase_o,
	output logic phase_ld_o,
	input logic [`OA_PHASE_W-1:0] phase_i,
	input logic phase_done_i
);

	logic phase_wr;
	logic phase_sel_msb;
	logic [`OA_DATA_W-1:0] phase_wdata;
	logic [`OA_DATA_W-1:0] phase_rdata;

	reg_bus_if bus ();

	// Sequencer and phase block run off combined reset
	host_cmd_fsm u_fsm (
		.ftdi_clk(ftdi_clk), .reset(reset_o),
		.cmdfifo_rxf_i(cmdfifo_rxf_i), .cmdfifo_txe_i(cmdfifo_txe_i),
		.cmdfifo_din_i(cmdfifo_din_i), .cmdfifo_rd_o(cmdfifo_rd_o),
		.cmdfifo_wr_o(cmdfifo_wr_o), .cmdfifo_isout_o(cmdfifo_isout_o),
		.cmdfifo_dout_o(cmdfifo_dout_o), .fifo_empty_i(fifo_empty_i),
		.fifo_data_i(fifo_data_i), .fifo_rd_en_o(fifo_rd_en_o), .bus(bus.seq)
	);

	adc_reg_file u_regs (
		.ftdi_clk(ftdi_clk), .reset_i(reset), .reset_o(reset_o), .bus(bus.regs),
		.status_i(status_i), .maxsamples_i(maxsamples_i), .gain_o(gain_o),
		.hilow_o(hilow_o), .trigger_mode_o(trigger_mode_o), .cmd_arm_o(cmd_arm_o),
		.trigger_wait_o(trigger_wait_o), .adc_clk_src_o(adc_clk_src_o),
		.maxsamples_o(maxsamples_o), .trigger_offset_o(trigger_offset_o),
		.phase_wr_o(phase_wr), .phase_sel_msb_o(phase_sel_msb),
		.phase_wdata_o(phase_wdata), .phase_rdata_i(phase_rdata)
	);

	phase_ctrl u_phase (
		.ftdi_clk(ftdi_clk), .reset(reset_o),
		.phase_wr_i(phase_wr), .phase_sel_msb_i(phase_sel_msb),
		.phase_wdata_i(phase_wdata), .phase_rdata_o(phase_rdata),
		.phase_o(phase_o), .phase_ld_o(phase_ld_o),
		.phase_i(phase_i), .phase_done_i(phase_done_i)
	);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_usb_interface -o sim_tb
out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -qx "NO ERRORS"; then
	exit 0
else
	exit 1
fi

// File: verilog.f
+incdir+hdl
hdl/openadc_pkg.sv
hdl/reg_bus_if.sv
hdl/host_cmd_fsm.sv
hdl/adc_reg_file.sv
hdl/phase_ctrl.sv
hdl/usb_interface.sv
dv/tb_clk_gen.sv
dv/usb_interface_props.sv
dv/tb_usb_interface.sv
